// File: include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and pc width
`define RV_XLEN 32
// register index width and count
`define RV_REG_AW 5
`define RV_NREGS 32
// first fetch address
`define RV_RESET_PC 32'h8000_0000

// major opcodes
`define RV_OP_IMM 7'h13
`define RV_OP_REG 7'h33
`define RV_OP_LUI 7'h37
`define RV_OP_AUIPC 7'h17
`define RV_OP_SYSTEM 7'h73
`define RV_INST_EBREAK 32'h0010_0073

// funct fields for add / addi
`define RV_F3_ADD 3'b000
`define RV_F7_ADD 7'b000_0000

`endif

// File: src/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

  // r-type layout, also the i-type layout
  // funct7 + rs2 together form imm[11:0] for addi
  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } inst_r_t;

  // u-type layout (lui, auipc)
  typedef struct packed {
    logic [19:0]           imm20;
    logic [`RV_REG_AW-1:0] rd;
    logic [6:0]            opcode;
  } inst_uv_t;

  // one instruction word, two decodings
  typedef union packed {
    inst_r_t  r;
    inst_uv_t u;
  } inst_u;

  // alu function select
  // add covers addi, add and auipc
  // pass_b is for lui
  typedef enum logic [1:0] {
    alu_add    = 2'd0,
    alu_pass_b = 2'd1
  } alu_op_e;

endpackage

// File: src/rv_decode_stage.sv
`include "rv_consts.svh"

module rv_decode_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`RV_XLEN-1:0]   inst,
  input  logic                  inst_valid,
  input  logic                  halted,
  output logic [`RV_XLEN-1:0]   pc,
  output logic                  d_valid,
  output logic [`RV_XLEN-1:0]   d_pc,
  output logic [`RV_REG_AW-1:0] d_rd,
  output logic [`RV_REG_AW-1:0] d_rs1,
  output logic [`RV_REG_AW-1:0] d_rs2,
  output logic [`RV_XLEN-1:0]   d_imm,
  output logic                  d_use_imm,
  output logic                  d_use_pc,
  output rv_pkg::alu_op_e       d_op,
  output logic                  d_wen,
  output logic                  d_not_impl,
  output logic                  d_ebreak
);

  rv_pkg::inst_u        iw;
  logic                 accept;
  logic [`RV_XLEN-1:0]  imm_i;
  logic [`RV_XLEN-1:0]  imm_u;
  logic [`RV_XLEN-1:0]  imm;
  logic                 use_imm;
  logic                 use_pc;
  rv_pkg::alu_op_e      op;
  logic                 impl;
  logic                 ebreak;

  assign iw     = inst;
  // nothing is taken once the core has halted
  assign accept = inst_valid & ~halted;

  // i-imm sits in funct7:rs2 of the r view
  assign imm_i = {{20{iw.r.funct7[6]}}, iw.r.funct7, iw.r.rs2};
  assign imm_u = {iw.u.imm20, 12'h000};

  // opcode classification
  always_comb begin
    imm     = imm_i;
    use_imm = 1'b0;
    use_pc  = 1'b0;
    op      = rv_pkg::alu_add;
    impl    = 1'b0;
    ebreak  = 1'b0;
    case (iw.r.opcode)
      `RV_OP_IMM: begin
        // addi only
        use_imm = 1'b1;
        impl    = (iw.r.funct3 == `RV_F3_ADD);
      end
      `RV_OP_REG: begin
        // plain add, sub and friends rejected
        impl = (iw.r.funct3 == `RV_F3_ADD) && (iw.r.funct7 == `RV_F7_ADD);
      end
      `RV_OP_LUI: begin
        imm     = imm_u;
        use_imm = 1'b1;
        op      = rv_pkg::alu_pass_b;
        impl    = 1'b1;
      end
      `RV_OP_AUIPC: begin
        imm     = imm_u;
        use_imm = 1'b1;
        use_pc  = 1'b1;
        impl    = 1'b1;
      end
      `RV_OP_SYSTEM: begin
        // whole word must match, ecall etc. stay unknown
        ebreak = (inst == `RV_INST_EBREAK);
        impl   = ebreak;
      end
      default: impl = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= `RV_RESET_PC;
      d_valid    <= 1'b0;
      d_pc       <= '0;
      d_rd       <= '0;
      d_rs1      <= '0;
      d_rs2      <= '0;
      d_imm      <= '0;
      d_use_imm  <= 1'b0;
      d_use_pc   <= 1'b0;
      d_op       <= rv_pkg::alu_add;
      d_wen      <= 1'b0;
      d_not_impl <= 1'b0;
      d_ebreak   <= 1'b0;
    end else begin
      d_valid <= accept;
      if (accept) begin
        pc         <= pc + 32'd4;
        d_pc       <= pc;
        d_rd       <= iw.r.rd;
        d_rs1      <= iw.r.rs1;
        d_rs2      <= iw.r.rs2;
        d_imm      <= imm;
        d_use_imm  <= use_imm;
        d_use_pc   <= use_pc;
        d_op       <= op;
        // no write for x0, ebreak or unknown words
        d_wen      <= impl & ~ebreak & (iw.r.rd != '0);
        d_not_impl <= ~impl;
        d_ebreak   <= ebreak;
      end
    end
  end

endmodule

// File: src/rv_regfile.sv
`include "rv_consts.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`RV_REG_AW-1:0] rs1_addr,
  input  logic [`RV_REG_AW-1:0] rs2_addr,
  input  logic                  wb_wen,
  input  logic [`RV_REG_AW-1:0] wb_rd,
  input  logic [`RV_XLEN-1:0]   wb_data,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);

  // x1..x31 only, x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_wen && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // same-cycle write shows on the read port
  always_comb begin
    if (rs1_addr == '0)
      rs1_data = '0;
    else if (wb_wen && (wb_rd == rs1_addr))
      rs1_data = wb_data;
    else
      rs1_data = regs[rs1_addr];

    if (rs2_addr == '0)
      rs2_data = '0;
    else if (wb_wen && (wb_rd == rs2_addr))
      rs2_data = wb_data;
    else
      rs2_data = regs[rs2_addr];
  end

endmodule

// File: src/rv_exec_stage.sv
`include "rv_consts.svh"

module rv_exec_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  d_valid,
  input  logic [`RV_XLEN-1:0]   d_pc,
  input  logic [`RV_REG_AW-1:0] d_rd,
  input  logic [`RV_REG_AW-1:0] d_rs1,
  input  logic [`RV_REG_AW-1:0] d_rs2,
  input  logic [`RV_XLEN-1:0]   d_imm,
  input  logic                  d_use_imm,
  input  logic                  d_use_pc,
  input  rv_pkg::alu_op_e       d_op,
  input  logic                  d_wen,
  input  logic                  d_not_impl,
  input  logic                  d_ebreak,
  input  logic [`RV_XLEN-1:0]   rs1_data,
  input  logic [`RV_XLEN-1:0]   rs2_data,
  input  logic                  wb_wen,
  input  logic [`RV_REG_AW-1:0] wb_rd,
  input  logic [`RV_XLEN-1:0]   wb_data,
  output logic [`RV_REG_AW-1:0] rs1_addr,
  output logic [`RV_REG_AW-1:0] rs2_addr,
  output logic                  e_valid,
  output logic [`RV_XLEN-1:0]   e_pc,
  output logic [`RV_REG_AW-1:0] e_rd,
  output logic [`RV_XLEN-1:0]   e_result,
  output logic                  e_wen,
  output logic                  e_not_impl,
  output logic                  e_ebreak
);

  logic [`RV_XLEN-1:0] src1;
  logic [`RV_XLEN-1:0] src2;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_out;

  // newest producer wins: own result reg, then writeback, then regfile
  function automatic logic [`RV_XLEN-1:0] fwd(
    input logic [`RV_REG_AW-1:0] idx,
    input logic [`RV_XLEN-1:0]   rf_val
  );
    if ((idx != '0) && e_wen && (e_rd == idx))
      return e_result;
    else if ((idx != '0) && wb_wen && (wb_rd == idx))
      return wb_data;
    else
      return rf_val;
  endfunction

  assign rs1_addr = d_rs1;
  assign rs2_addr = d_rs2;

  always_comb begin
    src1 = fwd(d_rs1, rs1_data);
    src2 = fwd(d_rs2, rs2_data);
  end

  // auipc takes pc on side a, imm forms go on side b
  assign op_a = d_use_pc ? d_pc : src1;
  assign op_b = d_use_imm ? d_imm : src2;

  always_comb begin
    case (d_op)
      rv_pkg::alu_add:    alu_out = op_a + op_b;
      rv_pkg::alu_pass_b: alu_out = op_b;
      default:            alu_out = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      e_valid    <= 1'b0;
      e_pc       <= '0;
      e_rd       <= '0;
      e_result   <= '0;
      e_wen      <= 1'b0;
      e_not_impl <= 1'b0;
      e_ebreak   <= 1'b0;
    end else begin
      e_valid    <= d_valid;
      e_pc       <= d_pc;
      e_rd       <= d_rd;
      e_result   <= alu_out;
      // bubbles carry no side effects
      e_wen      <= d_valid & d_wen;
      e_not_impl <= d_valid & d_not_impl;
      e_ebreak   <= d_valid & d_ebreak;
    end
  end

endmodule

// File: src/rv_wb_stage.sv
`include "rv_consts.svh"

module rv_wb_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  e_valid,
  input  logic [`RV_XLEN-1:0]   e_pc,
  input  logic [`RV_REG_AW-1:0] e_rd,
  input  logic [`RV_XLEN-1:0]   e_result,
  input  logic                  e_wen,
  input  logic                  e_not_impl,
  input  logic                  e_ebreak,
  output logic                  wb_wen,
  output logic [`RV_REG_AW-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]   wb_data,
  output logic                  retire_valid,
  output logic [`RV_XLEN-1:0]   retire_pc,
  output logic [`RV_REG_AW-1:0] retire_rd,
  output logic [`RV_XLEN-1:0]   retire_data,
  output logic                  retire_wen,
  output logic                  not_impl,
  output logic                  halted
);

  logic take;

  // anything behind an ebreak is dropped here
  assign take = e_valid & ~halted;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
      retire_pc    <= '0;
      retire_rd    <= '0;
      retire_data  <= '0;
      retire_wen   <= 1'b0;
      not_impl     <= 1'b0;
      halted       <= 1'b0;
    end else begin
      retire_valid <= take;
      retire_pc    <= e_pc;
      retire_rd    <= e_rd;
      retire_data  <= e_result;
      retire_wen   <= take & e_wen;
      // one-cycle pulse per unknown word
      not_impl     <= take & e_not_impl;
      // sticky until reset
      if (take && e_ebreak)
        halted <= 1'b1;
    end
  end

  // regfile write comes straight from the retire register
  assign wb_wen  = retire_wen;
  assign wb_rd   = retire_rd;
  assign wb_data = retire_data;

endmodule

// File: src/rv_core_top.sv
`include "rv_consts.svh"

module rv_core_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`RV_XLEN-1:0]   inst,
  input  logic                  inst_valid,
  output logic [`RV_XLEN-1:0]   pc,
  output logic                  retire_valid,
  output logic [`RV_XLEN-1:0]   retire_pc,
  output logic [`RV_REG_AW-1:0] retire_rd,
  output logic [`RV_XLEN-1:0]   retire_data,
  output logic                  retire_wen,
  output logic                  not_impl,
  output logic                  halted
);

  // decode -> execute
  logic                  d_valid;
  logic [`RV_XLEN-1:0]   d_pc;
  logic [`RV_REG_AW-1:0] d_rd;
  logic [`RV_REG_AW-1:0] d_rs1;
  logic [`RV_REG_AW-1:0] d_rs2;
  logic [`RV_XLEN-1:0]   d_imm;
  logic                  d_use_imm;
  logic                  d_use_pc;
  rv_pkg::alu_op_e       d_op;
  logic                  d_wen;
  logic                  d_not_impl;
  logic                  d_ebreak;

  // execute <-> regfile
  logic [`RV_REG_AW-1:0] rs1_addr;
  logic [`RV_REG_AW-1:0] rs2_addr;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;

  // execute -> writeback
  logic                  e_valid;
  logic [`RV_XLEN-1:0]   e_pc;
  logic [`RV_REG_AW-1:0] e_rd;
  logic [`RV_XLEN-1:0]   e_result;
  logic                  e_wen;
  logic                  e_not_impl;
  logic                  e_ebreak;

  // writeback -> regfile and forwarding
  logic                  wb_wen;
  logic [`RV_REG_AW-1:0] wb_rd;
  logic [`RV_XLEN-1:0]   wb_data;

  rv_decode_stage decode_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .inst_valid (inst_valid),
    .halted     (halted),
    .pc         (pc),
    .d_valid    (d_valid),
    .d_pc       (d_pc),
    .d_rd       (d_rd),
    .d_rs1      (d_rs1),
    .d_rs2      (d_rs2),
    .d_imm      (d_imm),
    .d_use_imm  (d_use_imm),
    .d_use_pc   (d_use_pc),
    .d_op       (d_op),
    .d_wen      (d_wen),
    .d_not_impl (d_not_impl),
    .d_ebreak   (d_ebreak)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wb_wen   (wb_wen),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_exec_stage exec_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .d_valid    (d_valid),
    .d_pc       (d_pc),
    .d_rd       (d_rd),
    .d_rs1      (d_rs1),
    .d_rs2      (d_rs2),
    .d_imm      (d_imm),
    .d_use_imm  (d_use_imm),
    .d_use_pc   (d_use_pc),
    .d_op       (d_op),
    .d_wen      (d_wen),
    .d_not_impl (d_not_impl),
    .d_ebreak   (d_ebreak),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .wb_wen     (wb_wen),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .e_valid    (e_valid),
    .e_pc       (e_pc),
    .e_rd       (e_rd),
    .e_result   (e_result),
    .e_wen      (e_wen),
    .e_not_impl (e_not_impl),
    .e_ebreak   (e_ebreak)
  );

  rv_wb_stage wb_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .e_valid      (e_valid),
    .e_pc         (e_pc),
    .e_rd         (e_rd),
    .e_result     (e_result),
    .e_wen        (e_wen),
    .e_not_impl   (e_not_impl),
    .e_ebreak     (e_ebreak),
    .wb_wen       (wb_wen),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .retire_wen   (retire_wen),
    .not_impl     (not_impl),
    .halted       (halted)
  );

endmodule

// File: sim/rv_core_asserts.sv
`include "rv_consts.svh"

module rv_core_asserts (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  inst_valid,
  input logic                  halted,
  input logic [`RV_XLEN-1:0]   pc,
  input logic                  retire_valid,
  input logic                  retire_wen,
  input logic [`RV_REG_AW-1:0] retire_rd
);
  timeunit 1ns;
  timeprecision 100ps;

  logic accept;
  // failed assertion count, read by the testbench
  int   fail_cnt = 0;

  // same condition the decode stage uses
  assign accept = inst_valid & ~halted;

  // taken at edge k, retire register loads at k+2, seen in the sample at k+3
  // an ebreak ahead of it may have dropped it
  retire_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> ##3 (retire_valid || halted))
    else begin
      fail_cnt++;
      $error("no retire two cycles after an accepted instruction");
    end

  // no retire without a matching accept
  retire_has_source: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> $past(accept, 3))
    else begin
      fail_cnt++;
      $error("retire without an accepted instruction two cycles before");
    end

  // sticky until reset
  halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted)
    else begin
      fail_cnt++;
      $error("halted dropped without reset");
    end

  no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    retire_wen |-> (retire_rd != '0))
    else begin
      fail_cnt++;
      $error("register write retired for x0");
    end

  // nothing is accepted once halted
  pc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> $stable(pc))
    else begin
      fail_cnt++;
      $error("pc moved while halted");
    end

endmodule

bind rv_core_top rv_core_asserts asserts_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .inst_valid   (inst_valid),
  .halted       (halted),
  .pc           (pc),
  .retire_valid (retire_valid),
  .retire_wen   (retire_wen),
  .retire_rd    (retire_rd)
);

// File: sim/rv_core_tb.sv
`include "rv_consts.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD    = 8;
  localparam int RESET_CYCLES  = 8;
  // rough cycle budget of each test, summed for the watchdog
  localparam int TEST_CYCLES   = 12 + 24 + 40 + 36 + 24 + 30;
  localparam int MARGIN_CYCLES = 200;
  localparam int SEED          = 37764;

  // one expected retire
  typedef struct packed {
    logic [31:0]           cyc;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
    logic                  wen;
    logic                  ni;
    logic                  ebrk;
    logic                  chk_data;
  } retire_t;

  logic                  clk;
  logic                  rst_n;
  logic [`RV_XLEN-1:0]   inst;
  logic                  inst_valid;
  logic [`RV_XLEN-1:0]   pc;
  logic                  retire_valid;
  logic [`RV_XLEN-1:0]   retire_pc;
  logic [`RV_REG_AW-1:0] retire_rd;
  logic [`RV_XLEN-1:0]   retire_data;
  logic                  retire_wen;
  logic                  not_impl;
  logic                  halted;

  // reference model state
  logic [`RV_XLEN-1:0] model_rf [0:`RV_NREGS-1];
  logic [`RV_XLEN-1:0] model_pc;
  logic                halt_issued = 1'b0;
  logic                halt_exp = 1'b0;
  retire_t             exp_q [$];
  int                  cyc = 0;
  int                  err_cnt = 0;
  int                  tests_run = 0;
  int                  tests_failed = 0;

  rv_core_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst         (inst),
    .inst_valid   (inst_valid),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .retire_wen   (retire_wen),
    .not_impl     (not_impl),
    .halted       (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // instruction encoders
  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, `RV_OP_IMM};
  endfunction

  function automatic logic [31:0] add_word(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {7'h00, rs2, rs1, 3'b000, rd, `RV_OP_REG};
  endfunction

  function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, `RV_OP_LUI};
  endfunction

  function automatic logic [31:0] auipc_word(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, `RV_OP_AUIPC};
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want) begin
      err_cnt++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, want);
    end
  endtask

  // drive one word and predict its retire from the model
  task automatic issue(input logic [31:0] w);
    retire_t             e;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] uimm;
    @(posedge clk);
    inst       <= w;
    inst_valid <= 1'b1;
    if (!halt_issued) begin
      a    = model_rf[w[19:15]];
      b    = model_rf[w[24:20]];
      uimm = {w[31:12], 12'h000};
      e    = '0;
      // taken at the next edge, retires two edges on, seen at that negedge
      e.cyc = cyc + 4;
      e.pc  = model_pc;
      e.rd  = w[11:7];
      case (w[6:0])
        `RV_OP_IMM: begin
          e.ni   = (w[14:12] != 3'b000);
          e.data = a + {{20{w[31]}}, w[31:20]};
        end
        `RV_OP_REG: begin
          e.ni   = (w[14:12] != 3'b000) || (w[31:25] != 7'h00);
          e.data = a + b;
        end
        `RV_OP_LUI:   e.data = uimm;
        `RV_OP_AUIPC: e.data = model_pc + uimm;
        `RV_OP_SYSTEM: begin
          e.ebrk = (w == `RV_INST_EBREAK);
          e.ni   = ~e.ebrk;
        end
        default: e.ni = 1'b1;
      endcase
      e.wen      = ~e.ni & ~e.ebrk & (e.rd != 5'd0);
      e.chk_data = e.wen;
      if (e.wen)
        model_rf[e.rd] = e.data;
      halt_issued = e.ebrk;
      model_pc    = model_pc + 32'd4;
      exp_q.push_back(e);
    end
  endtask

  // idle cycle, junk on the bus
  task automatic bubble;
    @(posedge clk);
    inst_valid <= 1'b0;
    inst       <= $urandom();
  endtask

  task automatic drain;
    @(posedge clk);
    inst_valid <= 1'b0;
    inst       <= '0;
    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (2) @(negedge clk);
    // hand back at a rising edge
    @(posedge clk);
  endtask

  // runs at every negedge once out of reset
  task automatic check_retire;
    retire_t e;
    if (retire_valid) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("t=%0t: unexpected retire at pc %h with nothing pending", $time, retire_pc);
      end else begin
        e = exp_q.pop_front();
        check_eq(cyc, e.cyc, "retire cycle");
        check_eq(retire_pc, e.pc, "retire_pc");
        check_eq(retire_rd, e.rd, "retire_rd");
        check_eq(retire_wen, e.wen, "retire_wen");
        check_eq(not_impl, e.ni, "not_impl");
        if (e.chk_data)
          check_eq(retire_data, e.data, "retire_data");
        // halted rises with the ebreak retire
        if (e.ebrk)
          halt_exp = 1'b1;
      end
    end else begin
      check_eq(not_impl, 1'b0, "not_impl without retire");
      if (exp_q.size() != 0) begin
        e = exp_q[0];
        if (e.cyc < cyc) begin
          err_cnt++;
          $display("t=%0t: instruction at pc %h never retired", $time, e.pc);
          e = exp_q.pop_front();
        end
      end
    end
    check_eq(halted, halt_exp, "halted");
  endtask

  always @(negedge clk) begin
    cyc = cyc + 1;
    if (rst_n)
      check_retire();
  end

  task automatic reset_values;
    @(negedge clk);
    check_eq(pc, `RV_RESET_PC, "pc after reset");
    check_eq(retire_valid, 1'b0, "retire_valid after reset");
    check_eq(halted, 1'b0, "halted after reset");
    check_eq(not_impl, 1'b0, "not_impl after reset");
  endtask

  task automatic upper_imm;
    logic [31:0] r;
    for (int i = 0; i < 8; i++) begin
      r = $urandom();
      if (i % 2 == 0)
        issue(lui_word(5'd1 + 5'(i), r[19:0]));
      else
        issue(auipc_word(5'd1 + 5'(i), r[19:0]));
    end
    drain();
    check_eq(pc, model_pc, "pc after lui/auipc run");
  endtask

  // each word reads the last three results
  task automatic dependent_chain;
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  p1;
    logic [4:0]  p2;
    logic [4:0]  p3;
    p1 = 5'd0;
    p2 = 5'd0;
    p3 = 5'd0;
    for (int i = 0; i < 16; i++) begin
      r  = $urandom();
      rd = 5'd5 + 5'(i % 4);
      if (i % 2 == 0)
        issue(addi_word(rd, p1, r[11:0]));
      else if (i % 4 == 1)
        issue(add_word(rd, p1, p2));
      else
        issue(add_word(rd, p1, p3));
      p3 = p2;
      p2 = p1;
      p1 = rd;
    end
    drain();
  endtask

  task automatic x0_and_bubbles;
    logic [31:0] r;
    r = $urandom();
    // both results dropped
    issue(addi_word(5'd0, 5'd5, r[11:0]));
    issue(lui_word(5'd0, r[31:12]));
    bubble();
    issue(addi_word(5'd9, 5'd0, r[23:12]));
    for (int i = 0; i < 6; i++) begin
      r = $urandom();
      repeat (r[1:0]) bubble();
      if (i % 2 == 0)
        issue(addi_word(5'd10, 5'd10, r[15:4]));
      else
        issue(add_word(5'd11, 5'd0, 5'd10));
    end
    drain();
    check_eq(pc, model_pc, "pc after bubbles");
  endtask

  task automatic unknown_opcode;
    issue(addi_word(5'd5, 5'd0, 12'h123));
    // lw, sub, ecall, slli
    issue({12'h004, 5'd0, 3'b010, 5'd5, 7'h03});
    issue({7'h20, 5'd5, 5'd5, 3'b000, 5'd5, `RV_OP_REG});
    issue(32'h0000_0073);
    issue({12'h001, 5'd5, 3'b001, 5'd5, `RV_OP_IMM});
    // x5 must still hold 0x123
    issue(add_word(5'd12, 5'd5, 5'd0));
    drain();
  endtask

  task automatic ebreak_halt;
    logic [`RV_XLEN-1:0] pc_hold;
    issue(addi_word(5'd13, 5'd0, 12'h055));
    issue(`RV_INST_EBREAK);
    // none of these may retire
    for (int i = 0; i < 4; i++)
      issue(addi_word(5'd14, 5'd13, 12'h001));
    drain();
    check_eq(halted, 1'b1, "halted after ebreak");
    pc_hold = pc;
    for (int i = 0; i < 4; i++)
      issue(lui_word(5'd15, 20'habcde));
    drain();
    check_eq(pc, pc_hold, "pc while halted");
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d check(s) failed", name, err_cnt - errs_before);
    end
  endtask

  initial begin
    int errs;
    rst_n      = 1'b0;
    inst       = '0;
    inst_valid = 1'b0;
    void'($urandom(SEED));
    for (int i = 0; i < `RV_NREGS; i++)
      model_rf[i] = '0;
    model_pc = `RV_RESET_PC;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    errs = err_cnt;
    reset_values();
    report_test("reset_values", errs);
    errs = err_cnt;
    upper_imm();
    report_test("upper_imm", errs);
    errs = err_cnt;
    dependent_chain();
    report_test("dependent_chain", errs);
    errs = err_cnt;
    x0_and_bubbles();
    report_test("x0_and_bubbles", errs);
    errs = err_cnt;
    unknown_opcode();
    report_test("unknown_opcode", errs);
    // halt is sticky, so this one goes last
    errs = err_cnt;
    ebreak_halt();
    report_test("ebreak_halt", errs);

    // bound assertion failures count as failed checks too
    err_cnt = err_cnt + dut_i.asserts_i.fail_cnt;
    $display("%0d tests run, %0d failed, %0d failed checks", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog: the run did not finish within %0d cycles and was stopped",
             RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
src/rv_pkg.sv
src/rv_decode_stage.sv
src/rv_regfile.sv
src/rv_exec_stage.sv
src/rv_wb_stage.sv
src/rv_core_top.sv
sim/rv_core_asserts.sv
sim/rv_core_tb.sv
